//--- src/branch_pkg.sv
/*
  Branch resolution package
  Shared widths, opcodes, condition codes, table geometry, sequencer
  state codes and the two views of the branch instruction word
*/
package branch_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int XLEN    = 16;   // Data and address width
  localparam int OPC_W   = 4;    // Opcode field
  localparam int CC_W    = 3;    // Condition code field
  localparam int IMM_W   = 9;    // B offset, in half-words
  localparam int FLAGS_W = 3;    // Z/V/N

  // Opcodes of the two branch forms
  localparam logic [OPC_W-1:0] OP_B  = 4'b1100;  // PC-relative
  localparam logic [OPC_W-1:0] OP_BR = 4'b1101;  // Register target

  // Condition codes
  localparam logic [CC_W-1:0] CC_NE  = 3'b000;
  localparam logic [CC_W-1:0] CC_EQ  = 3'b001;
  localparam logic [CC_W-1:0] CC_GT  = 3'b010;
  localparam logic [CC_W-1:0] CC_LT  = 3'b011;
  localparam logic [CC_W-1:0] CC_GE  = 3'b100;
  localparam logic [CC_W-1:0] CC_LE  = 3'b101;
  localparam logic [CC_W-1:0] CC_OV  = 3'b110;
  localparam logic [CC_W-1:0] CC_UNC = 3'b111;   // Always taken

  // Bit positions in the flags word
  localparam int FLAG_Z = 2;
  localparam int FLAG_V = 1;
  localparam int FLAG_N = 0;

  ////////////////////////////////////////////////////////////
  // Table geometry
  ////////////////////////////////////////////////////////////
  localparam int TBL_IDX_W = 4;                 // Index is PC[4:1]
  localparam int TBL_DEPTH = 1 << TBL_IDX_W;
  localparam int TAG_W     = XLEN - TBL_IDX_W - 1;  // Tag is PC[15:5]

  localparam logic [1:0] BHT_RESET_CNT = 2'b01;  // Weakly not taken

  // Sequencer states
  localparam int         ST_W       = 2;
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_LOOKUP  = 2'd1;
  localparam logic [1:0] ST_RESOLVE = 2'd2;
  localparam logic [1:0] ST_DONE    = 2'd3;

  // One instruction word, read as B or BR format
  typedef union packed {
    struct packed {
      logic [OPC_W-1:0] opcode;
      logic [CC_W-1:0]  cond;
      logic [IMM_W-1:0] imm9;     // Signed half-word offset
    } b_fmt;
    struct packed {
      logic [OPC_W-1:0] opcode;
      logic [CC_W-1:0]  cond;
      logic [3:0]       rs;       // Source register number
      logic [4:0]       rsvd;
    } br_fmt;
  } instr_u;

endpackage

//--- src/branch_control.sv
/*
  Branch control
  Decodes B/BR, evaluates the condition against Z/V/N, forms the branch
  target and the actual next PC, and raises the table write enables.
  Purely combinational
*/
`timescale 1ns/1ps
module branch_control (
  input  logic [branch_pkg::OPC_W-1:0]   opcode,
  input  logic [branch_pkg::CC_W-1:0]    cond,
  input  logic [branch_pkg::IMM_W-1:0]   imm9,
  input  logic [branch_pkg::FLAGS_W-1:0] flags,
  input  logic [branch_pkg::XLEN-1:0]    rs_data,
  input  logic [branch_pkg::XLEN-1:0]    pc_next,           // PC+2
  input  logic [branch_pkg::XLEN-1:0]    predicted_target,
  output logic                           is_branch,
  output logic                           cond_taken,
  output logic [branch_pkg::XLEN-1:0]    pc_branch,         // Target if taken
  output logic [branch_pkg::XLEN-1:0]    actual_target,
  output logic                           wen_bht,
  output logic                           wen_btb
);
  import branch_pkg::*;

  logic             is_br;        // Register branch
  logic             flag_z;
  logic             flag_v;
  logic             flag_n;
  logic [XLEN-1:0]  sext_off;     // Offset in half-words
  logic [XLEN-1:0]  pc_b;         // PC-relative target

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  assign is_branch = (opcode == OP_B) || (opcode == OP_BR);
  assign is_br     = (opcode == OP_BR);

  assign flag_z = flags[FLAG_Z];
  assign flag_v = flags[FLAG_V];
  assign flag_n = flags[FLAG_N];

  // Condition evaluation
  always_comb begin
    case (cond)
      CC_NE:   cond_taken = ~flag_z;
      CC_EQ:   cond_taken = flag_z;
      CC_GT:   cond_taken = ~flag_z & ~flag_n;   // Z = N = 0
      CC_LT:   cond_taken = flag_n;
      CC_GE:   cond_taken = flag_z | ~flag_n;    // Equal or greater
      CC_LE:   cond_taken = flag_z | flag_n;
      CC_OV:   cond_taken = flag_v;
      default: cond_taken = 1'b1;                // CC_UNC
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////
  assign sext_off = {{(XLEN-IMM_W){imm9[IMM_W-1]}}, imm9};
  assign pc_b     = pc_next + {sext_off[XLEN-2:0], 1'b0};  // Offset times two

  // BR ignores the low field and jumps to Rs
  assign pc_branch = is_br ? rs_data : pc_b;

  // Fall through to PC+2 when not a branch or not taken
  assign actual_target = (is_branch && cond_taken) ? pc_branch : pc_next;

  // Every branch trains the BHT
  assign wen_bht = is_branch;

  // BTB learns taken branches and any stale target
  assign wen_btb = is_branch & (cond_taken | (pc_branch != predicted_target));

endmodule

//--- src/branch_history_table.sv
/*
  Branch history table
  Sixteen 2-bit saturating counters, registered read and synchronous
  update. Upper counter bit is the taken prediction
*/
`timescale 1ns/1ps
module branch_history_table (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [branch_pkg::TBL_IDX_W-1:0]  rd_idx,
  output logic [1:0]                        rd_cnt,
  input  logic                              upd_en,
  input  logic [branch_pkg::TBL_IDX_W-1:0]  upd_idx,
  input  logic                              upd_taken
);
  import branch_pkg::*;

  logic [1:0] cnt [TBL_DEPTH];   // Counter array

  // Counter update, saturating at both ends
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TBL_DEPTH; i++) begin
        cnt[i] <= BHT_RESET_CNT;   // All weakly not taken
      end
    end else if (upd_en) begin
      if (upd_taken && cnt[upd_idx] != 2'b11) begin
        cnt[upd_idx] <= cnt[upd_idx] + 2'd1;
      end else if (!upd_taken && cnt[upd_idx] != 2'b00) begin
        cnt[upd_idx] <= cnt[upd_idx] - 2'd1;
      end
    end
  end

  // One-cycle read
  always_ff @(posedge clk) begin
    rd_cnt <= cnt[rd_idx];
  end

endmodule

//--- src/branch_target_buffer.sv
/*
  Branch target buffer
  Direct-mapped, 16 entries of valid, tag and target. The tag compare
  sits in front of the read register, so hit arrives with the target
*/
`timescale 1ns/1ps
module branch_target_buffer (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [branch_pkg::TBL_IDX_W-1:0]  rd_idx,
  input  logic [branch_pkg::TAG_W-1:0]      rd_tag,
  output logic                              hit,
  output logic [branch_pkg::XLEN-1:0]       rd_target,
  input  logic                              wr_en,
  input  logic [branch_pkg::TBL_IDX_W-1:0]  wr_idx,
  input  logic [branch_pkg::TAG_W-1:0]      wr_tag,
  input  logic [branch_pkg::XLEN-1:0]       wr_target
);
  import branch_pkg::*;

  logic [TBL_DEPTH-1:0] valid;
  logic [TAG_W-1:0]     tag_mem [TBL_DEPTH];
  logic [XLEN-1:0]      tgt_mem [TBL_DEPTH];

  ////////////////////////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // Tag and target storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx] <= wr_tag;
      tgt_mem[wr_idx] <= wr_target;
    end
  end

  // Registered lookup
  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
    end else begin
      hit <= valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);   // Tag match on a live entry
    end
  end

  always_ff @(posedge clk) begin
    rd_target <= tgt_mem[rd_idx];
  end

endmodule

//--- src/branch_sequencer.sv
/*
  Branch sequencer
  Four-phase req/ack FSM. Captures one request, looks the PC up in the
  BHT and BTB, forms the prediction, registers the resolved outcome and
  pulses the table updates. ack rises on the third edge after req is
  seen and falls when req is seen low
*/
`timescale 1ns/1ps
module branch_sequencer (
  input  logic                              clk,
  input  logic                              rst,
  // Handshake and request
  input  logic                              req,
  output logic                              ack,
  input  logic [branch_pkg::XLEN-1:0]       instr,
  input  logic [branch_pkg::XLEN-1:0]       pc,
  input  logic [branch_pkg::FLAGS_W-1:0]    flags,
  input  logic [branch_pkg::XLEN-1:0]       rs_data,
  // Results
  output logic                              taken,
  output logic [branch_pkg::XLEN-1:0]       actual_target,
  output logic [branch_pkg::XLEN-1:0]       predicted_target,
  output logic                              mispredict,
  // Table side
  output logic [branch_pkg::TBL_IDX_W-1:0]  lookup_idx,
  output logic [branch_pkg::TAG_W-1:0]      lookup_tag,
  output logic                              bht_upd_en,
  output logic                              btb_wr_en,
  output logic [branch_pkg::TBL_IDX_W-1:0]  upd_idx,
  output logic [branch_pkg::TAG_W-1:0]      upd_tag,
  output logic                              upd_taken,
  output logic [branch_pkg::XLEN-1:0]       btb_wr_target,
  input  logic [1:0]                        bht_cnt,
  input  logic                              btb_hit,
  input  logic [branch_pkg::XLEN-1:0]       btb_target,
  // To branch_control
  output logic [branch_pkg::OPC_W-1:0]      opcode,
  output logic [branch_pkg::CC_W-1:0]       cond,
  output logic [branch_pkg::IMM_W-1:0]      imm9,
  output logic [branch_pkg::FLAGS_W-1:0]    flags_q,
  output logic [branch_pkg::XLEN-1:0]       rs_q,
  output logic [branch_pkg::XLEN-1:0]       pc_next,
  output logic [branch_pkg::XLEN-1:0]       pred_q,
  // From branch_control
  input  logic                              is_branch,
  input  logic                              cond_taken,
  input  logic [branch_pkg::XLEN-1:0]       pc_branch,
  input  logic [branch_pkg::XLEN-1:0]       res_target,
  input  logic                              wen_bht,
  input  logic                              wen_btb
);
  import branch_pkg::*;

  logic [ST_W-1:0] state;
  instr_u          instr_q;   // Captured instruction
  logic [XLEN-1:0] pc_q;
  logic            capture;   // Request accepted this edge
  logic            resolve;

  assign capture = (state == ST_IDLE) && req;
  assign resolve = (state == ST_RESOLVE);

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      ack        <= 1'b0;
      taken      <= 1'b0;
      mispredict <= 1'b0;
    end else begin
      case (state)
        ST_IDLE:   if (req) state <= ST_LOOKUP;   // Edge 1
        ST_LOOKUP: state <= ST_RESOLVE;           // Edge 2, tables read
        ST_RESOLVE: begin                         // Edge 3, results out
          state      <= ST_DONE;
          ack        <= 1'b1;
          taken      <= is_branch & cond_taken;
          mispredict <= is_branch & (res_target != pred_q);
        end
        ST_DONE: begin
          if (!req) begin                         // Requester released
            state <= ST_IDLE;
            ack   <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request and result payload
  always_ff @(posedge clk) begin
    if (capture) begin
      instr_q <= instr;
      pc_q    <= pc;
      flags_q <= flags;
      rs_q    <= rs_data;
    end
    if (resolve) begin
      actual_target    <= res_target;
      predicted_target <= pred_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Lookup, prediction and update
  ////////////////////////////////////////////////////////////
  assign lookup_idx = pc_q[TBL_IDX_W:1];          // Half-word aligned PC
  assign lookup_tag = pc_q[XLEN-1 -: TAG_W];
  assign pc_next    = pc_q + XLEN'(2);

  // Predict the BTB target only on a hit with a taken-leaning counter
  assign pred_q = (btb_hit && bht_cnt[1]) ? btb_target : pc_next;

  // Field extraction through both views
  assign opcode = instr_q.b_fmt.opcode;
  assign cond   = instr_q.br_fmt.cond;
  assign imm9   = instr_q.b_fmt.imm9;

  // Table writes land on edge 3
  assign bht_upd_en    = resolve & wen_bht;
  assign btb_wr_en     = resolve & wen_btb;
  assign upd_idx       = lookup_idx;
  assign upd_tag       = lookup_tag;
  assign upd_taken     = is_branch & cond_taken;
  assign btb_wr_target = pc_branch;

endmodule

//--- src/branch_unit.sv
/*
  Branch unit top
  Connects the handshake sequencer, the BHT, the BTB and the branch
  control logic
*/
`timescale 1ns/1ps
module branch_unit (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req,
  input  logic [branch_pkg::XLEN-1:0]     instr,
  input  logic [branch_pkg::XLEN-1:0]     pc,
  input  logic [branch_pkg::FLAGS_W-1:0]  flags,
  input  logic [branch_pkg::XLEN-1:0]     rs_data,
  output logic                            ack,
  output logic                            taken,
  output logic [branch_pkg::XLEN-1:0]     actual_target,
  output logic [branch_pkg::XLEN-1:0]     predicted_target,
  output logic                            mispredict
);
  import branch_pkg::*;

  // Table interface
  logic [TBL_IDX_W-1:0] lookup_idx;
  logic [TAG_W-1:0]     lookup_tag;
  logic                 bht_upd_en;
  logic                 btb_wr_en;
  logic [TBL_IDX_W-1:0] upd_idx;
  logic [TAG_W-1:0]     upd_tag;
  logic                 upd_taken;
  logic [XLEN-1:0]      btb_wr_target;
  logic [1:0]           bht_cnt;
  logic                 btb_hit;
  logic [XLEN-1:0]      btb_target;

  // Sequencer to branch_control
  logic [OPC_W-1:0]     opcode;
  logic [CC_W-1:0]      cond;
  logic [IMM_W-1:0]     imm9;
  logic [FLAGS_W-1:0]   flags_q;
  logic [XLEN-1:0]      rs_q;
  logic [XLEN-1:0]      pc_next;
  logic [XLEN-1:0]      pred_q;
  logic                 is_branch;
  logic                 cond_taken;
  logic [XLEN-1:0]      pc_branch;
  logic [XLEN-1:0]      res_target;
  logic                 wen_bht;
  logic                 wen_btb;

  branch_sequencer u_seq (
    .clk, .rst, .req, .ack, .instr, .pc, .flags, .rs_data,
    .taken, .actual_target, .predicted_target, .mispredict,
    .lookup_idx, .lookup_tag, .bht_upd_en, .btb_wr_en,
    .upd_idx, .upd_tag, .upd_taken, .btb_wr_target,
    .bht_cnt, .btb_hit, .btb_target,
    .opcode, .cond, .imm9, .flags_q, .rs_q, .pc_next, .pred_q,
    .is_branch, .cond_taken, .pc_branch, .res_target, .wen_bht, .wen_btb
  );

  branch_history_table u_bht (
    .clk,
    .rst,
    .rd_idx    (lookup_idx),
    .rd_cnt    (bht_cnt),
    .upd_en    (bht_upd_en),
    .upd_idx   (upd_idx),
    .upd_taken (upd_taken)
  );

  branch_target_buffer u_btb (
    .clk,
    .rst,
    .rd_idx    (lookup_idx),
    .rd_tag    (lookup_tag),
    .hit       (btb_hit),
    .rd_target (btb_target),
    .wr_en     (btb_wr_en),
    .wr_idx    (upd_idx),
    .wr_tag    (upd_tag),
    .wr_target (btb_wr_target)
  );

  branch_control u_ctl (
    .opcode           (opcode),
    .cond             (cond),
    .imm9             (imm9),
    .flags            (flags_q),
    .rs_data          (rs_q),
    .pc_next          (pc_next),
    .predicted_target (pred_q),
    .is_branch        (is_branch),
    .cond_taken       (cond_taken),
    .pc_branch        (pc_branch),
    .actual_target    (res_target),
    .wen_bht          (wen_bht),
    .wen_btb          (wen_btb)
  );

endmodule

//--- testbench/tb_branch_vectors.svh
/*
  Directed branch vectors
  Condition codes, B offsets of both signs, BR targets, a non-branch
  between two lookups of one PC, and training at a single index
*/
`ifndef TB_BRANCH_VECTORS_SVH
`define TB_BRANCH_VECTORS_SVH

localparam int NUM_DIRECTED = 14;

// Columns: pc, instr, flags {Z,V,N}, rs_data, expected taken, expected actual_target
task automatic load_vectors();
  // B UNC +4 three times at one PC, counter crosses into taken
  add_vector(16'h0100, 16'hCE04, 3'b000, 16'h0000, 1'b1, 16'h010A);
  add_vector(16'h0100, 16'hCE04, 3'b000, 16'h0000, 1'b1, 16'h010A);
  add_vector(16'h0100, 16'hCE04, 3'b000, 16'h0000, 1'b1, 16'h010A);
  // Same index, other tag, EQ with Z clear
  add_vector(16'h0900, 16'hC3FE, 3'b000, 16'h0000, 1'b0, 16'h0902);
  // NE taken, offset -8
  add_vector(16'h0206, 16'hC1F8, 3'b000, 16'h0000, 1'b1, 16'h01F8);
  add_vector(16'h030A, 16'hDE60, 3'b000, 16'h4A5C, 1'b1, 16'h4A5C);  // BR UNC
  add_vector(16'h0314, 16'hD6A0, 3'b000, 16'h1234, 1'b0, 16'h0316);  // BR LT, N clear
  add_vector(16'h0318, 16'hD6A0, 3'b001, 16'h2222, 1'b1, 16'h2222);  // BR LT, N set
  // Non-branch at a trained PC, then the branch again
  add_vector(16'h0206, 16'h1E04, 3'b000, 16'h0000, 1'b0, 16'h0208);
  add_vector(16'h0206, 16'hC1F8, 3'b000, 16'h0000, 1'b1, 16'h01F8);
  add_vector(16'h041C, 16'hC4FF, 3'b000, 16'h0000, 1'b1, 16'h061C);  // GT, largest offset
  add_vector(16'h1012, 16'hCD00, 3'b010, 16'h0000, 1'b1, 16'h0E14);  // OV, most negative
  add_vector(16'h2004, 16'hCA10, 3'b000, 16'h0000, 1'b0, 16'h2006);  // LE, flags clear
  add_vector(16'h2008, 16'hC820, 3'b001, 16'h0000, 1'b0, 16'h200A);  // GE with N set
endtask

`endif

//--- testbench/tb_branch_unit.sv
/*
  Branch unit testbench
  Runs directed vectors and a seeded sweep of condition codes and flags
  through the four-phase handshake. A BHT/BTB model predicts the
  predicted target and the mispredict flag
*/
`timescale 1ns/1ps
module tb_branch_unit;
  import branch_pkg::*;

  localparam int          CLK_PERIOD = 4;
  localparam int          RST_CYCLES = 16;
  localparam int          NUM_RANDOM = 64;      // All cond x flags pairs
  localparam logic [15:0] SEED       = 16'd38925;

  logic        clk;
  logic        rst;
  logic        req;
  logic [15:0] instr;
  logic [15:0] pc;
  logic [2:0]  flags;
  logic [15:0] rs_data;
  logic        ack;
  logic        taken;
  logic [15:0] actual_target;
  logic [15:0] predicted_target;
  logic        mispredict;

  int          errors = 0;
  int          checks = 0;
  logic [15:0] lfsr   = SEED;

  // Directed vector columns
  logic [15:0] v_pc[$];
  logic [15:0] v_instr[$];
  logic [2:0]  v_flags[$];
  logic [15:0] v_rs[$];
  logic        v_taken[$];
  logic [15:0] v_target[$];

  // Reference BHT/BTB
  logic [1:0]       m_cnt   [TBL_DEPTH];
  logic             m_valid [TBL_DEPTH];
  logic [TAG_W-1:0] m_tag   [TBL_DEPTH];
  logic [15:0]      m_tgt   [TBL_DEPTH];

  task automatic add_vector(input logic [15:0] a_pc, input logic [15:0] a_instr,
                            input logic [2:0] a_flags, input logic [15:0] a_rs,
                            input logic a_taken, input logic [15:0] a_target);
    v_pc.push_back(a_pc);
    v_instr.push_back(a_instr);
    v_flags.push_back(a_flags);
    v_rs.push_back(a_rs);
    v_taken.push_back(a_taken);
    v_target.push_back(a_target);
  endtask

  `include "tb_branch_vectors.svh"

  localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 20 + RST_CYCLES;

  branch_unit i_dut (
    .clk, .rst, .req, .instr, .pc, .flags, .rs_data,
    .ack, .taken, .actual_target, .predicted_target, .mispredict
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////
  // Galois LFSR, one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic cond_met(input logic [2:0] c, input logic [2:0] f);
    logic z;
    logic v;
    logic n;
    z = f[FLAG_Z];
    v = f[FLAG_V];
    n = f[FLAG_N];
    case (c)
      CC_NE:   return !z;
      CC_EQ:   return z;
      CC_GT:   return !z && !n;
      CC_LT:   return n;
      CC_GE:   return z || !n;
      CC_LE:   return z || n;
      CC_OV:   return v;
      default: return 1'b1;         // Unconditional
    endcase
  endfunction

  // Target if taken, B is PC-relative in half-words
  function automatic logic [15:0] branch_target(input logic [15:0] p, input logic [15:0] ins,
                                                input logic [15:0] rs);
    logic [15:0] off;
    off = {{7{ins[8]}}, ins[8:0]};
    if (ins[15:12] == OP_BR) return rs;
    return p + 16'd2 + (off << 1);
  endfunction

  task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One four-phase transaction plus model update
  ////////////////////////////////////////////////////////////
  task automatic run_txn(input logic [15:0] t_pc, input logic [15:0] t_instr,
                         input logic [2:0] t_flags, input logic [15:0] t_rs,
                         input logic exp_taken, input logic [15:0] exp_target);
    logic [TBL_IDX_W-1:0] idx;
    logic [TAG_W-1:0]     tag;
    logic                 is_br;
    logic [15:0]          tgt;
    logic [15:0]          pred;
    logic                 exp_mis;
    int                   waited;
    idx     = t_pc[4:1];
    tag     = t_pc[15:5];
    is_br   = (t_instr[15:12] == OP_B) || (t_instr[15:12] == OP_BR);
    tgt     = branch_target(t_pc, t_instr, t_rs);
    pred    = (m_valid[idx] && m_tag[idx] == tag && m_cnt[idx][1]) ? m_tgt[idx] : t_pc + 16'd2;
    exp_mis = is_br && (exp_target != pred);

    @(posedge clk);
    req     <= 1'b1;
    pc      <= t_pc;
    instr   <= t_instr;
    flags   <= t_flags;
    rs_data <= t_rs;
    waited = 0;
    @(negedge clk);                // Rising edges counted from here on
    while (!ack) begin             // Sampled mid-cycle
      @(negedge clk);
      waited++;
    end
    check("ack latency in cycles", waited, 16'd3);
    check("taken", taken, exp_taken);
    check("actual_target", actual_target, exp_target);
    check("predicted_target", predicted_target, pred);
    check("mispredict", mispredict, exp_mis);

    // Keep req high, results must not move
    repeat (2) begin
      @(negedge clk);
      check("ack while req high", ack, 1'b1);
      check("taken held", taken, exp_taken);
      check("actual_target held", actual_target, exp_target);
      check("predicted_target held", predicted_target, pred);
      check("mispredict held", mispredict, exp_mis);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check("ack before req seen low", ack, 1'b1);
    @(negedge clk);
    check("ack after req seen low", ack, 1'b0);

    if (is_br) begin
      if (exp_taken && m_cnt[idx] != 2'b11) m_cnt[idx] = m_cnt[idx] + 2'd1;
      else if (!exp_taken && m_cnt[idx] != 2'b00) m_cnt[idx] = m_cnt[idx] - 2'd1;
      if (exp_taken || tgt != pred) begin   // BTB learns
        m_valid[idx] = 1'b1;
        m_tag[idx]   = tag;
        m_tgt[idx]   = tgt;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [15:0] r_bits;
    logic [15:0] r_pc;
    logic [3:0]  r_op;
    logic [15:0] r_instr;
    logic [2:0]  r_flags;
    logic [15:0] r_rs;
    logic        r_taken;
    rst     = 1'b1;
    req     = 1'b0;
    instr   = '0;
    pc      = '0;
    flags   = '0;
    rs_data = '0;
    for (int k = 0; k < TBL_DEPTH; k++) begin
      m_cnt[k]   = BHT_RESET_CNT;
      m_valid[k] = 1'b0;
    end
    load_vectors();

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("ack after reset", ack, 1'b0);

    foreach (v_pc[k]) begin
      run_txn(v_pc[k], v_instr[k], v_flags[k], v_rs[k], v_taken[k], v_target[k]);
    end

    // Sweep cond and flags, random PC, form, offset and Rs
    for (int k = 0; k < NUM_RANDOM; k++) begin
      r_bits  = rand_bits(8);
      r_pc    = {7'h00, r_bits[7:0], 1'b0};   // Small range so tables hit
      r_op    = rand_bits(1) ? OP_BR : OP_B;
      r_bits  = rand_bits(9);
      r_instr = {r_op, k[2:0], r_bits[8:0]};
      r_flags = k[5:3];
      r_rs    = rand_bits(16);
      r_taken = cond_met(k[2:0], r_flags);
      run_txn(r_pc, r_instr, r_flags, r_rs, r_taken,
              r_taken ? branch_target(r_pc, r_instr, r_rs) : r_pc + 16'd2);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+testbench
src/branch_pkg.sv
src/branch_control.sv
src/branch_history_table.sv
src/branch_target_buffer.sv
src/branch_sequencer.sv
src/branch_unit.sv
testbench/tb_branch_unit.sv
